/* Bender.yml */
package:
  name: ll_queue_mgr

sources:
  # Package and interface ahead of the modules that use them
  - verilog/ll_pkg.sv
  - verilog/ll_fetch_if.sv
  # Storage, pointer management and scheduling
  - verilog/ll_ram.sv
  - verilog/ll_free_fifo.sv
  - verilog/ll_queue_table.sv
  - verilog/ll_sched_fsm.sv
  - verilog/ll_out_db.sv
  # Top level
  - verilog/ll_top.sv
  # Testbench
  - target: simulation
    files:
      - bench/tb_ll_top.sv

/* bench/tb_ll_top.sv */
//------------------------------
// Testbench for the linked-list queue manager
// Clock, reset and random stream stimulus
// Model queues, assertions and watchdog
//------------------------------
`default_nettype none

module tb_ll_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_WORDS = 2000;
  // Pool entries plus both buffer slots
  localparam int STALL_WORDS = ll_pkg::POOL_DEPTH + 2;
  localparam int IDLE_CYCLES = 20;
  localparam int DUTY_CYCLES = 64;
  localparam int MODE_RANDOM = 0;
  localparam int MODE_READY = 1;
  localparam int MODE_HOLD = 2;
  localparam logic [31:0] SEED = 32'h20ae519a;
  // Forty cycles for every transfer of the random phase
  localparam longint WATCHDOG_NS = longint'(NUM_WORDS) * 40 * CLK_PERIOD;

  logic clk;
  logic rst_n;
  logic in_valid;
  logic in_ready;
  ll_pkg::qid_t in_qid;
  ll_pkg::data_t in_data;
  logic out_valid;
  logic out_ready;
  ll_pkg::qid_t out_qid;
  ll_pkg::data_t out_data;
  logic overflow;

  // Reference order of the words still owed, one queue per qid
  ll_pkg::data_t model_q [ll_pkg::NUM_QUEUES][$];
  int exp_len [ll_pkg::NUM_QUEUES];
  ll_pkg::data_t exp_front [ll_pkg::NUM_QUEUES];
  int total_len;
  logic exp_avail;
  ll_pkg::data_t exp_data;
  // Edges seen since reset release, saturating
  int since_rst;
  int stall_cnt;
  logic stall_mode;
  logic drain_mode;
  // Output word of the last edge that was held back
  logic held_valid;
  ll_pkg::qid_t held_qid;
  ll_pkg::data_t held_data;
  int duty;
  int phase_cnt;
  int sent;

  ll_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_qid    (in_qid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_qid   (out_qid),
    .out_data  (out_data),
    .overflow  (overflow)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic abort_run(input string reason);
    $display("=== FAIL ===");
    $fatal(1, "%s", reason);
  endtask

  //------------------------------
  // Scoreboard
  //------------------------------

  // Pops come first, a word accepted on this edge can only leave later
  always @(posedge clk or negedge rst_n) begin : scoreboard
    int sum;
    if (!rst_n) begin
      for (int q = 0; q < ll_pkg::NUM_QUEUES; q++) begin
        model_q[q].delete();
        exp_len[q] <= 0;
        exp_front[q] <= '0;
      end
      total_len <= 0;
    end else begin
      if (out_valid && out_ready && (model_q[out_qid].size() != 0)) begin
        void'(model_q[out_qid].pop_front());
      end
      if (in_valid && in_ready) begin
        model_q[in_qid].push_back(in_data);
      end
      sum = 0;
      for (int q = 0; q < ll_pkg::NUM_QUEUES; q++) begin
        exp_len[q] <= model_q[q].size();
        exp_front[q] <= (model_q[q].size() != 0) ? model_q[q][0] : '0;
        sum += model_q[q].size();
      end
      total_len <= sum;
    end
  end

  assign exp_avail = (exp_len[out_qid] != 0);
  assign exp_data = exp_front[out_qid];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      since_rst <= 0;
      stall_cnt <= 0;
      held_valid <= 1'b0;
      held_qid <= '0;
      held_data <= '0;
    end else begin
      if (since_rst <= ll_pkg::POOL_DEPTH) begin
        since_rst <= since_rst + 1;
      end
      if (!stall_mode) begin
        stall_cnt <= 0;
      end else if (in_valid && in_ready) begin
        stall_cnt <= stall_cnt + 1;
      end
      held_valid <= out_valid && !out_ready;
      held_qid <= out_qid;
      held_data <= out_data;
    end
  end

  //------------------------------
  // Assertions
  //------------------------------

  a_no_ready_in_reset : assert property (@(posedge clk) !rst_n |-> !in_ready)
    else begin
      $display("CHECK FAILED at %0t ns: in_ready = %b, expected 0", $time, $sampled(in_ready));
      abort_run("in_ready was high during reset");
    end

  // The pool fill takes exactly POOL_DEPTH cycles
  a_ready_after_init : assert property (@(posedge clk)
    (rst_n && (since_rst <= ll_pkg::POOL_DEPTH)) |->
      (in_ready == (since_rst == ll_pkg::POOL_DEPTH)))
    else begin
      $display("CHECK FAILED at %0t ns: in_ready = %b, expected %b", $time,
               $sampled(in_ready), $sampled(since_rst == ll_pkg::POOL_DEPTH));
      abort_run("in_ready did not rise exactly after the pool fill");
    end

  a_idle_at_start : assert property (@(posedge clk)
    (!rst_n || (since_rst <= ll_pkg::POOL_DEPTH)) |-> !out_valid)
    else begin
      $display("CHECK FAILED at %0t ns: out_valid = %b, expected 0", $time, $sampled(out_valid));
      abort_run("out_valid was high before any input");
    end

  a_queue_order : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready) |-> (exp_avail && (out_data == exp_data)))
    else begin
      if (!$sampled(exp_avail)) begin
        $display("Word left on queue %0d at %0t ns with nothing owed on that queue",
                 $sampled(out_qid), $time);
      end else begin
        $display("CHECK FAILED at %0t ns: out_data = %h, expected %h", $time,
                 $sampled(out_data), $sampled(exp_data));
      end
      abort_run("output word does not match the queue order");
    end

  // A word held back by out_ready must stay put
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    held_valid |-> (out_valid && (out_qid == held_qid) && (out_data == held_data)))
    else begin
      if (!$sampled(out_valid)) begin
        $display("CHECK FAILED at %0t ns: out_valid = %b, expected 1", $time, $sampled(out_valid));
      end else begin
        $display("CHECK FAILED at %0t ns: out_qid/out_data = %0d/%h, expected %0d/%h",
                 $time, $sampled(out_qid), $sampled(out_data),
                 $sampled(held_qid), $sampled(held_data));
      end
      abort_run("output changed under back-pressure");
    end

  // Nothing may come out once every owed word has left
  a_drain_idle : assert property (@(posedge clk) disable iff (!rst_n)
    drain_mode |-> !out_valid)
    else begin
      $display("CHECK FAILED at %0t ns: out_valid = %b, expected 0", $time, $sampled(out_valid));
      abort_run("queue manager not idle after draining");
    end

  a_stall_fill : assert property (@(posedge clk) disable iff (!rst_n)
    stall_mode |-> (in_ready == (stall_cnt < STALL_WORDS)))
    else begin
      $display("CHECK FAILED at %0t ns: in_ready = %b, expected %b after %0d words", $time,
               $sampled(in_ready), $sampled(stall_cnt < STALL_WORDS), $sampled(stall_cnt));
      abort_run("wrong number of words accepted with out_ready low");
    end

  a_no_overflow : assert property (@(posedge clk) rst_n |-> !overflow)
    else begin
      $display("CHECK FAILED at %0t ns: overflow = %b, expected 0", $time, $sampled(overflow));
      abort_run("output buffer overflow");
    end

  //------------------------------
  // Stimulus
  //------------------------------

  // One clock of stimulus; input data holds until it is accepted
  task automatic run_cycle(input logic send, input logic dense, input int out_mode);
    @(posedge clk);
    if (in_valid && in_ready) begin
      sent++;
    end
    if (!send) begin
      in_valid <= 1'b0;
    end else if (!in_valid || in_ready) begin
      if (dense || ($urandom_range(3, 0) != 0)) begin
        in_valid <= 1'b1;
        in_qid <= ll_pkg::qid_t'($urandom_range(ll_pkg::NUM_QUEUES - 1, 0));
        in_data <= $urandom;
      end else begin
        in_valid <= 1'b0;
      end
    end
    // Duty of out_ready in quarters, changed every few dozen cycles
    phase_cnt++;
    if ((phase_cnt % DUTY_CYCLES) == 0) begin
      duty = $urandom_range(4, 1);
    end
    case (out_mode)
      MODE_HOLD: out_ready <= 1'b0;
      MODE_READY: out_ready <= 1'b1;
      default: out_ready <= ($urandom_range(3, 0) < duty);
    endcase
  endtask

  // Two lead cycles let the scoreboard see the last accepted word
  task automatic drain_and_check();
    repeat (2) run_cycle(1'b0, 1'b0, MODE_READY);
    while (total_len != 0) begin
      run_cycle(1'b0, 1'b0, MODE_READY);
    end
    drain_mode <= 1'b1;
    repeat (IDLE_CYCLES) @(posedge clk);
    drain_mode <= 1'b0;
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns before the tests finished", $time);
    abort_run("simulation timed out");
  end

  initial begin : main
    void'($urandom(SEED));
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_qid = '0;
    in_data = '0;
    out_ready = 1'b0;
    stall_mode = 1'b0;
    drain_mode = 1'b0;
    duty = 4;
    phase_cnt = 0;
    sent = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    do begin
      @(posedge clk);
    end while (!in_ready);

    // Random traffic on all queues with changing output duty
    while (sent < NUM_WORDS) begin
      run_cycle(1'b1, 1'b0, MODE_RANDOM);
    end
    drain_and_check();

    // Fill pool and buffer with the output blocked
    run_cycle(1'b1, 1'b1, MODE_HOLD);
    stall_mode <= 1'b1;
    while (stall_cnt < STALL_WORDS) begin
      run_cycle(1'b1, 1'b1, MODE_HOLD);
    end
    repeat (IDLE_CYCLES) run_cycle(1'b1, 1'b1, MODE_HOLD);
    run_cycle(1'b0, 1'b0, MODE_READY);
    stall_mode <= 1'b0;
    while (!in_ready) begin
      run_cycle(1'b0, 1'b0, MODE_READY);
    end
    drain_and_check();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/ll_pkg.sv
verilog/ll_fetch_if.sv
verilog/ll_ram.sv
verilog/ll_free_fifo.sv
verilog/ll_queue_table.sv
verilog/ll_sched_fsm.sv
verilog/ll_out_db.sv
verilog/ll_top.sv
bench/tb_ll_top.sv

/* verilog/ll_fetch_if.sv */
//------------------------------
// Head fetch interface
// Scheduler request, queue table head lookup
// and the RAM response one cycle later
//------------------------------
`default_nettype none

interface ll_fetch_if;

  // Single-cycle fetch strobe, never refused
  logic fetch_valid;
  logic [ll_pkg::QID_W-1:0] fetch_qid;

  // Head lookup for fetch_qid
  logic [ll_pkg::PTR_W-1:0] fetch_ptr;
  // Set when the fetched queue holds exactly one entry
  logic fetch_last;
  logic [ll_pkg::NUM_QUEUES-1:0] q_nonempty;

  // Storage response, one cycle after fetch_valid
  logic rsp_valid;
  logic [ll_pkg::DATA_W-1:0] rsp_data;
  logic [ll_pkg::PTR_W-1:0] rsp_next;

  modport sched (
    output fetch_valid, fetch_qid,
    input q_nonempty, rsp_valid
  );

  modport tbl (
    input fetch_valid, fetch_qid, rsp_next,
    output fetch_ptr, fetch_last, q_nonempty
  );

  modport mem (
    input fetch_valid, fetch_ptr,
    output rsp_valid, rsp_data, rsp_next
  );

endinterface

`default_nettype wire

/* verilog/ll_free_fifo.sv */
//------------------------------
// Free pointer FIFO
// Fills itself with pointers 0 to POOL_DEPTH-1
// after reset, then allocates and releases
//------------------------------
`default_nettype none

module ll_free_fifo (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         alloc,
  output ll_pkg::ptr_t alloc_ptr,
  input  logic         release_en,
  input  ll_pkg::ptr_t release_ptr,
  output logic         init_done,
  output logic         empty
);

  ll_pkg::ptr_t fifo [ll_pkg::POOL_DEPTH];
  ll_pkg::ptr_t wr_idx;
  ll_pkg::ptr_t rd_idx;
  ll_pkg::cnt_t cnt;
  // Counts the pointers written during the fill phase
  ll_pkg::cnt_t init_cnt;
  logic filling;
  logic push;
  logic pop;
  ll_pkg::ptr_t push_ptr;
  logic full;

  assign filling = (init_cnt != ll_pkg::cnt_t'(ll_pkg::POOL_DEPTH));

  // Raised while the last pointer goes in, so the scheduler leaves INIT
  // on the same edge that completes the fill
  assign init_done = (init_cnt >= ll_pkg::cnt_t'(ll_pkg::POOL_DEPTH - 1));

  // During the fill the counter owns the write side
  assign push = filling | release_en;
  assign push_ptr = filling ? ll_pkg::ptr_t'(init_cnt) : release_ptr;
  assign pop = alloc;

  assign alloc_ptr = fifo[rd_idx];
  assign empty = (cnt == '0);
  assign full = (cnt == ll_pkg::cnt_t'(ll_pkg::POOL_DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_cnt <= '0;
      wr_idx <= '0;
      rd_idx <= '0;
      cnt <= '0;
    end else begin
      if (filling) begin
        init_cnt <= init_cnt + 1'b1;
      end
      if (push) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (pop) begin
        rd_idx <= rd_idx + 1'b1;
      end
      // Alloc and release in one cycle leave the count unchanged
      cnt <= cnt + ll_pkg::cnt_t'(push) - ll_pkg::cnt_t'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_idx] <= push_ptr;
    end
  end

  // The scheduler must only link while a pointer is free, and the pool
  // can never hand back more pointers than it owns
  a_no_underflow_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(alloc && empty) && !(release_en && full)
  ) else $error("free pointer FIFO misuse");

endmodule

`default_nettype wire

/* verilog/ll_out_db.sv */
//------------------------------
// Output double buffer
// Two slots, dual push, single pop,
// fill level and sticky overflow flag
//------------------------------
`default_nettype none

module ll_out_db (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  ll_pkg::out_entry_t  push_data,
  input  logic                push_2,
  input  ll_pkg::out_entry_t  push_data_2,
  input  logic                pop,
  output ll_pkg::out_entry_t  pop_data,
  output ll_pkg::db_level_t   level,
  output logic                overflow
);

  ll_pkg::out_entry_t slot [2];
  logic wp;
  logic rp;
  logic [1:0] depth;
  // Wide enough to see a third entry
  logic [2:0] depth_sum;
  logic wp_2;
  logic ovf;

  assign depth_sum = {1'b0, depth} + {2'b00, push} + {2'b00, push_2} - {2'b00, pop};

  // The second port takes the slot the first one leaves
  assign wp_2 = push ? ~wp : wp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wp <= 1'b0;
      rp <= 1'b0;
      depth <= '0;
      ovf <= 1'b0;
    end else begin
      wp <= wp + push + push_2;
      rp <= rp + pop;
      depth <= depth_sum[1:0];
      // Once set, the error stays until reset
      if (depth_sum > 3'd2) begin
        ovf <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      slot[wp] <= push_data;
    end
    if (push_2) begin
      slot[wp_2] <= push_data_2;
    end
  end

  assign pop_data = slot[rp];
  assign level = ovf ? 2'd3 : depth;
  assign overflow = ovf;

  // The scheduler credit must keep pushes within two slots
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    level != 2'd3
  ) else $error("output double buffer overflow");

endmodule

`default_nettype wire

/* verilog/ll_pkg.sv */
//------------------------------
// Shared definitions of the linked-list queue manager
// Pool geometry and widths
// Index, count and level types
// Output double buffer entry
//------------------------------
`default_nettype none

package ll_pkg;

  //------------------------------
  // Geometry
  //------------------------------

  // Logical queues sharing the pool
  localparam int NUM_QUEUES = 4;
  // Storage entries in the shared pool
  localparam int POOL_DEPTH = 16;
  localparam int DATA_W = 32;

  localparam int QID_W = $clog2(NUM_QUEUES);
  localparam int PTR_W = $clog2(POOL_DEPTH);
  // Occupancy counters must also hold the value POOL_DEPTH
  localparam int CNT_W = $clog2(POOL_DEPTH + 1);

  //------------------------------
  // Types
  //------------------------------

  typedef logic [QID_W-1:0] qid_t;
  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [DATA_W-1:0] data_t;

  // One word waiting in the output buffer, tagged with its queue
  typedef struct packed {
    qid_t qid;
    data_t data;
  } out_entry_t;

  // Buffer fill level, 3 marks an overflow
  typedef logic [1:0] db_level_t;

endpackage

`default_nettype wire

/* verilog/ll_queue_table.sv */
//------------------------------
// Queue table
// Head, tail and entry count per queue
// Updated on link and on head fetch
//------------------------------
`default_nettype none

module ll_queue_table (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          link_en,
  input  ll_pkg::qid_t  link_qid,
  input  ll_pkg::ptr_t  link_ptr,
  output ll_pkg::ptr_t  tail_ptr,
  output logic          tail_valid,
  ll_fetch_if.tbl       fetch
);

  ll_pkg::ptr_t head [ll_pkg::NUM_QUEUES];
  ll_pkg::ptr_t tail [ll_pkg::NUM_QUEUES];
  ll_pkg::cnt_t cnt [ll_pkg::NUM_QUEUES];

  // Head update owed from the next-pointer RAM on the response cycle
  logic pend;
  ll_pkg::qid_t pend_qid;
  // A link that lands on the entry being fetched right now
  logic link_on_last;

  //------------------------------
  // Lookups
  //------------------------------

  assign fetch.fetch_ptr = head[fetch.fetch_qid];
  assign fetch.fetch_last = (cnt[fetch.fetch_qid] == ll_pkg::cnt_t'(1));

  // The top level writes the next link at the old tail when the queue is not empty
  assign tail_ptr = tail[link_qid];
  assign tail_valid = (cnt[link_qid] != '0);

  assign link_on_last = link_en && fetch.fetch_valid && fetch.fetch_last &&
                        (fetch.fetch_qid == link_qid);

  always_comb begin
    for (int q = 0; q < ll_pkg::NUM_QUEUES; q++) begin
      fetch.q_nonempty[q] = (cnt[q] != '0);
    end
  end

  //------------------------------
  // Counts and pending update
  //------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int q = 0; q < ll_pkg::NUM_QUEUES; q++) begin
        cnt[q] <= '0;
      end
      pend <= 1'b0;
      pend_qid <= '0;
    end else begin
      for (int q = 0; q < ll_pkg::NUM_QUEUES; q++) begin
        cnt[q] <= cnt[q]
                  + ll_pkg::cnt_t'(link_en && (link_qid == ll_pkg::qid_t'(q)))
                  - ll_pkg::cnt_t'(fetch.fetch_valid && (fetch.fetch_qid == ll_pkg::qid_t'(q)));
      end
      // Only a queue that keeps entries needs the next pointer as its head
      pend <= fetch.fetch_valid && !fetch.fetch_last;
      pend_qid <= fetch.fetch_qid;
    end
  end

  //------------------------------
  // Head and tail pointers
  //------------------------------

  always_ff @(posedge clk) begin
    if (pend) begin
      head[pend_qid] <= fetch.rsp_next;
    end
    if (link_en) begin
      tail[link_qid] <= link_ptr;
      // An empty queue, or one whose only entry leaves now, starts at the new entry
      if ((cnt[link_qid] == '0) || link_on_last) begin
        head[link_qid] <= link_ptr;
      end
    end
  end

  // The scheduler must never pick a queue that this table reports empty
  a_fetch_nonempty : assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch.fetch_valid |-> (cnt[fetch.fetch_qid] != '0)
  ) else $error("fetch issued to an empty queue");

endmodule

`default_nettype wire

/* verilog/ll_ram.sv */
//------------------------------
// Pool storage RAM
// One write port and one registered read port
// Payload type set by parameter
//------------------------------
`default_nettype none

module ll_ram #(
  parameter type T = logic
) (
  input  logic         clk,
  input  logic         wr_en,
  input  ll_pkg::ptr_t wr_addr,
  input  T             wr_data,
  input  logic         rd_en,
  input  ll_pkg::ptr_t rd_addr,
  output T             rd_data
);

  // One entry per pool pointer
  T mem [ll_pkg::POOL_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port with one cycle of latency
  // A write to the same address in this cycle is not seen, the old value comes out
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* verilog/ll_sched_fsm.sv */
//------------------------------
// Scheduler FSM
// Init wait, round-robin head fetch,
// bypass or link choice and buffer credit
//------------------------------
`default_nettype none

module ll_sched_fsm (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              init_done,
  input  ll_pkg::db_level_t db_level,
  input  logic              out_pop,
  input  logic              in_valid,
  input  ll_pkg::qid_t      in_qid,
  input  logic              free_empty,
  output logic              in_ready,
  output logic              bypass,
  output logic              link_en,
  ll_fetch_if.sched         fetch
);

  typedef enum logic {
    INIT,
    RUN
  } state_t;

  state_t state;
  logic run;
  // Round-robin start point and the queue fetched last cycle
  ll_pkg::qid_t rr_ptr;
  ll_pkg::qid_t last_qid;
  ll_pkg::qid_t cand;
  ll_pkg::qid_t pick_qid;
  logic pick_ok;
  // Free buffer slots this cycle, counting the pop and the word in flight
  logic [2:0] slots;
  logic [2:0] byp_slots;
  logic byp_ok;
  logic accept;

  assign run = (state == RUN);

  //------------------------------
  // Credit
  //------------------------------

  assign slots = 3'd2 + {2'b00, out_pop} - {1'b0, db_level} - {2'b00, fetch.rsp_valid};
  // A bypass may only use a slot left over after this cycle's fetch
  assign byp_slots = slots - {2'b00, fetch.fetch_valid};

  //------------------------------
  // Round-robin pick
  //------------------------------

  always_comb begin
    pick_ok = 1'b0;
    pick_qid = rr_ptr;
    cand = rr_ptr;
    for (int i = 0; i < ll_pkg::NUM_QUEUES; i++) begin
      cand = rr_ptr + ll_pkg::qid_t'(i);
      // The head of a queue fetched last cycle is not updated yet
      if (!pick_ok && fetch.q_nonempty[cand] &&
          !(fetch.rsp_valid && (cand == last_qid))) begin
        pick_ok = 1'b1;
        pick_qid = cand;
      end
    end
  end

  assign fetch.fetch_valid = run && pick_ok && (slots != 3'd0);
  assign fetch.fetch_qid = pick_qid;

  //------------------------------
  // Input side
  //------------------------------

  // Bypass keeps order since the queue holds nothing and a word still in
  // flight from it is pushed ahead on the first buffer port
  assign byp_ok = run && !fetch.q_nonempty[in_qid] &&
                  !(fetch.fetch_valid && (fetch.fetch_qid == in_qid)) &&
                  (byp_slots != 3'd0);

  assign in_ready = run && (!free_empty || byp_ok);
  assign accept = in_valid && in_ready;
  assign bypass = accept && byp_ok;
  assign link_en = accept && !byp_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= INIT;
      rr_ptr <= '0;
      last_qid <= '0;
    end else begin
      case (state)
        INIT: begin
          if (init_done) begin
            state <= RUN;
          end
        end
        RUN: begin
          if (fetch.fetch_valid) begin
            // Next search starts past the queue just served
            rr_ptr <= pick_qid + 1'b1;
            last_qid <= pick_qid;
          end
        end
        default: state <= INIT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/ll_top.sv */
//------------------------------
// Linked-list queue manager top level
// Free FIFO, queue table, scheduler, data and
// next RAMs, output double buffer
//------------------------------
`default_nettype none

module ll_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  output logic          in_ready,
  input  ll_pkg::qid_t  in_qid,
  input  ll_pkg::data_t in_data,
  output logic          out_valid,
  input  logic          out_ready,
  output ll_pkg::qid_t  out_qid,
  output ll_pkg::data_t out_data,
  output logic          overflow
);

  ll_fetch_if u_fetch_if ();

  logic init_done;
  logic free_empty;
  logic link_en;
  logic bypass;
  logic out_pop;
  ll_pkg::ptr_t alloc_ptr;
  ll_pkg::ptr_t tail_ptr;
  logic tail_valid;
  // Fetch details kept for the response cycle
  ll_pkg::qid_t rsp_qid;
  ll_pkg::ptr_t rsp_ptr;
  ll_pkg::db_level_t db_level;
  ll_pkg::out_entry_t fetch_entry;
  ll_pkg::out_entry_t bypass_entry;
  ll_pkg::out_entry_t pop_entry;

  //------------------------------
  // Pointer and queue state
  //------------------------------

  // The fetched entry returns to the pool as soon as its data is read
  ll_free_fifo u_free_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc       (link_en),
    .alloc_ptr   (alloc_ptr),
    .release_en  (u_fetch_if.rsp_valid),
    .release_ptr (rsp_ptr),
    .init_done   (init_done),
    .empty       (free_empty)
  );

  ll_queue_table u_queue_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .link_en    (link_en),
    .link_qid   (in_qid),
    .link_ptr   (alloc_ptr),
    .tail_ptr   (tail_ptr),
    .tail_valid (tail_valid),
    .fetch      (u_fetch_if.tbl)
  );

  ll_sched_fsm u_sched_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .init_done  (init_done),
    .db_level   (db_level),
    .out_pop    (out_pop),
    .in_valid   (in_valid),
    .in_qid     (in_qid),
    .free_empty (free_empty),
    .in_ready   (in_ready),
    .bypass     (bypass),
    .link_en    (link_en),
    .fetch      (u_fetch_if.sched)
  );

  //------------------------------
  // Storage
  //------------------------------

  // Linked word lands at its allocated pointer in the accept cycle
  ll_ram #(.T(ll_pkg::data_t)) u_data_ram (
    .clk     (clk),
    .wr_en   (link_en),
    .wr_addr (alloc_ptr),
    .wr_data (in_data),
    .rd_en   (u_fetch_if.fetch_valid),
    .rd_addr (u_fetch_if.fetch_ptr),
    .rd_data (u_fetch_if.rsp_data)
  );

  // The old tail now points to the new entry
  ll_ram #(.T(ll_pkg::ptr_t)) u_next_ram (
    .clk     (clk),
    .wr_en   (link_en && tail_valid),
    .wr_addr (tail_ptr),
    .wr_data (alloc_ptr),
    .rd_en   (u_fetch_if.fetch_valid),
    .rd_addr (u_fetch_if.fetch_ptr),
    .rd_data (u_fetch_if.rsp_next)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      u_fetch_if.rsp_valid <= 1'b0;
    end else begin
      u_fetch_if.rsp_valid <= u_fetch_if.fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (u_fetch_if.fetch_valid) begin
      rsp_qid <= u_fetch_if.fetch_qid;
      rsp_ptr <= u_fetch_if.fetch_ptr;
    end
  end

  //------------------------------
  // Output buffer
  //------------------------------

  assign fetch_entry = '{qid: rsp_qid, data: u_fetch_if.rsp_data};
  assign bypass_entry = '{qid: in_qid, data: in_data};

  // Fetched word on the first port so it leaves ahead of a same-cycle bypass
  ll_out_db u_out_db (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (u_fetch_if.rsp_valid),
    .push_data   (fetch_entry),
    .push_2      (bypass),
    .push_data_2 (bypass_entry),
    .pop         (out_pop),
    .pop_data    (pop_entry),
    .level       (db_level),
    .overflow    (overflow)
  );

  assign out_valid = (db_level != 2'd0);
  assign out_pop = out_valid && out_ready;
  assign out_qid = pop_entry.qid;
  assign out_data = pop_entry.data;

endmodule

`default_nettype wire
